// ==== bench/processorTb.sv ====
// processorTb: runs programs on the single-cycle core and compares against a reference model
`include "core_macros.svh"

module processorTb import isaPkg::*, corePkg::*; ();

	logic clk;
	logic rst;
	logic loadValid;
	logic loadReady;
	pc_t loadAddr;
	logic [31:0] loadInstr;
	logic start;
	pc_t pc;
	logic halted;
	logic [31:0] cyclesConsumed;
	logic [4:0] dbgAddr;
	logic [31:0] dbgData;

	word_t modelRegs [`REG_COUNT];
	word_t modelMem [`DMEM_DEPTH];
	logic [31:0] modelImem [`IMEM_DEPTH];
	logic [31:0] prog [$];
	funct_e functList [5] = '{add, sub, andOp, orOp, slt};
	int errorCount = 0;
	int testsPassed = 0;
	int cycleCount = 0;
	int cycleBudget = 40; // reset and a margin to start with
	int expCount;
	pc_t expPc;
	integer seed = 59;

	processor i_processor (
		.clk(clk),
		.rst(rst),
		.loadValid(loadValid),
		.loadReady(loadReady),
		.loadAddr(loadAddr),
		.loadInstr(loadInstr),
		.start(start),
		.pc(pc),
		.halted(halted),
		.cyclesConsumed(cyclesConsumed),
		.dbgAddr(dbgAddr),
		.dbgData(dbgData)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// the counter only moves while a program executes
	assert property (@(posedge clk) disable iff (!rst)
		($changed(cyclesConsumed) && !halted) |-> !loadReady)
	else begin
		$display("loadReady was high while the core was running, at %0t", $time);
		errorCount++;
	end

	assert property (@(posedge clk) disable iff (!rst) halted |-> $stable(pc))
	else begin
		$display("pc moved while the core was halted, at %0t", $time);
		errorCount++;
	end

	function automatic logic [31:0] encodeR(funct_e f, int rd, int rs, int rt);
		return {rType, rs[4:0], rt[4:0], rd[4:0], 5'd0, f};
	endfunction

	function automatic logic [31:0] encodeI(opcode_e op, int rt, int rs, int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic logic [31:0] encodeHalt();
		return {hlt, 26'd0};
	endfunction

	function automatic void modelWrite(logic [4:0] r, word_t value);
		if (r != 5'd0) begin
			modelRegs[r] = value; // register 0 stays zero
		end
	endfunction

	task automatic modelExecute(output int count, output pc_t finalPc);
		pc_t mPc;
		logic [31:0] ins;
		word_t valA;
		word_t valB;
		word_t sImm;
		word_t addr;
		logic done;
		mPc = '0;
		count = 0;
		done = 1'b0;
		while (!done && count < 1000) begin
			ins = modelImem[mPc];
			valA = modelRegs[ins[25:21]];
			valB = modelRegs[ins[20:16]];
			sImm = {{16{ins[15]}}, ins[15:0]};
			addr = valA + sImm;
			count++;
			case (ins[31:26])
				rType: begin
					case (ins[5:0])
						add: modelWrite(ins[15:11], valA + valB);
						sub: modelWrite(ins[15:11], valA - valB);
						andOp: modelWrite(ins[15:11], valA & valB);
						orOp: modelWrite(ins[15:11], valA | valB);
						slt: modelWrite(ins[15:11], {31'd0, $signed(valA) < $signed(valB)});
						default: ;
					endcase
					mPc++;
				end
				addi: begin
					modelWrite(ins[20:16], addr);
					mPc++;
				end
				lw: begin
					modelWrite(ins[20:16], modelMem[addr % `DMEM_DEPTH]);
					mPc++;
				end
				sw: begin
					modelMem[addr % `DMEM_DEPTH] = valB;
					mPc++;
				end
				beq: mPc = (valA == valB) ? mPc + pc_t'(ins[`PC_WIDTH-1:0]) : mPc + pc_t'(1);
				hlt: done = 1'b1; // pc stays on the hlt
				default: mPc++;
			endcase
		end
		if (!done) begin
			$display("reference model never reached a hlt instruction");
			errorCount++;
		end
		finalPc = mPc;
	endtask

	task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
		assert (actual === expected)
		else begin
			$display("mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic loadProgram();
		logic accepted;
		cycleBudget += 2 * prog.size() + 10;
		@(posedge clk);
		foreach (prog[i]) begin
			loadValid <= 1'b1;
			loadAddr <= pc_t'(i);
			loadInstr <= prog[i];
			modelImem[i] = prog[i];
			do begin
				@(negedge clk);
				accepted = loadReady; // transfer happens on the coming edge
				@(posedge clk);
			end while (!accepted);
		end
		loadValid <= 1'b0;
	endtask

	task automatic pulseStart();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic checkRegs();
		for (int r = 0; r < `REG_COUNT; r++) begin
			@(posedge clk);
			dbgAddr <= 5'(r);
			@(negedge clk);
			checkValue($sformatf("dbgData[r%0d]", r), modelRegs[r], dbgData);
		end
	endtask

	task automatic runAndCheck();
		modelExecute(expCount, expPc);
		cycleBudget += expCount + 50;
		pulseStart();
		do @(negedge clk); while (!halted);
		checkValue("pc", 32'(expPc), 32'(pc));
		checkValue("cyclesConsumed", expCount, cyclesConsumed);
		checkRegs();
	endtask

	task automatic finishTest(int num, string name, int errorsBefore);
		if (errorCount == errorsBefore) begin
			testsPassed++;
			$display("test %0d %s: passed", num, name);
		end else begin
			$display("test %0d %s: failed with %0d errors", num, name, errorCount - errorsBefore);
		end
	endtask

	initial begin
		int errorsBefore;
		logic accepted;
		int len;
		int rd;
		int rs;
		int rt;
		int imm;
		rst = 1'b0;
		loadValid = 1'b0;
		loadAddr = '0;
		loadInstr = '0;
		start = 1'b0;
		dbgAddr = '0;
		foreach (modelRegs[r])
			modelRegs[r] = '0;
		repeat (8) @(posedge clk);
		rst <= 1'b1;

		errorsBefore = errorCount;
		@(negedge clk);
		checkValue("loadReady", 1, loadReady);
		checkValue("halted", 0, halted);
		checkValue("pc", 0, 32'(pc));
		checkValue("cyclesConsumed", 0, cyclesConsumed);
		prog = '{encodeI(addi, 1, 0, 3), encodeI(beq, 0, 1, 3), encodeI(addi, 1, 1, -1),
			encodeI(beq, 0, 0, -2), encodeHalt()};
		loadProgram();
		modelExecute(expCount, expPc);
		cycleBudget += expCount + 50;
		pulseStart();
		loadValid <= 1'b1; // host offers a word while the program runs
		loadAddr <= pc_t'(`IMEM_DEPTH - 1);
		loadInstr <= encodeHalt();
		modelImem[`IMEM_DEPTH - 1] = encodeHalt();
		do begin
			@(negedge clk);
			accepted = loadReady;
			if (!halted)
				checkValue("loadReady", 0, loadReady);
			@(posedge clk);
		end while (!accepted);
		loadValid <= 1'b0;
		@(negedge clk);
		checkValue("halted", 1, halted);
		checkValue("pc", 32'(expPc), 32'(pc));
		checkValue("cyclesConsumed", expCount, cyclesConsumed);
		finishTest(1, "reset and load back-pressure", errorsBefore);

		errorsBefore = errorCount;
		prog = '{encodeI(addi, 1, 0, 25), encodeI(addi, 2, 0, -7),
			encodeR(add, 3, 1, 2), encodeR(sub, 4, 2, 1), encodeR(andOp, 5, 1, 2),
			encodeR(orOp, 6, 1, 2), encodeR(slt, 7, 2, 1), encodeR(slt, 8, 1, 2),
			encodeR(sub, 9, 0, 1), encodeR(slt, 10, 9, 2), encodeHalt()};
		loadProgram();
		runAndCheck();
		finishTest(2, "R-type arithmetic", errorsBefore);

		errorsBefore = errorCount;
		prog = '{encodeI(addi, 11, 0, -1), encodeI(addi, 12, 11, -32768),
			encodeI(addi, 13, 0, 32767), encodeI(addi, 0, 13, 5), encodeR(add, 0, 13, 13),
			encodeI(addi, 14, 0, 0), encodeHalt()};
		loadProgram();
		runAndCheck();
		finishTest(3, "addi sign extension and r0", errorsBefore);

		errorsBefore = errorCount;
		prog = '{encodeI(addi, 1, 0, 10), encodeI(addi, 2, 0, -100),
			encodeI(sw, 2, 1, 0), encodeI(sw, 1, 1, 5), encodeI(addi, 3, 0, 200),
			encodeI(sw, 3, 3, 55), encodeI(sw, 2, 1, -10), encodeI(lw, 4, 1, 0),
			encodeI(lw, 5, 1, 5), encodeI(lw, 6, 3, 55), encodeI(lw, 7, 0, 0), encodeHalt()};
		loadProgram();
		runAndCheck();
		finishTest(4, "store and load", errorsBefore);

		errorsBefore = errorCount;
		prog = '{encodeI(addi, 1, 0, 5), encodeI(addi, 2, 0, 0), encodeI(beq, 0, 1, 4),
			encodeR(add, 2, 2, 1), encodeI(addi, 1, 1, -1), encodeI(beq, 0, 0, -3),
			encodeI(addi, 3, 0, 7), encodeHalt()};
		loadProgram();
		runAndCheck();
		finishTest(5, "countdown loop", errorsBefore);

		errorsBefore = errorCount;
		for (int p = 0; p < 10; p++) begin
			len = 6 + ($unsigned($random(seed)) % 10);
			prog.delete();
			repeat (len) begin
				rd = $random(seed) & 31;
				rs = $random(seed) & 31;
				rt = $random(seed) & 31;
				imm = $random(seed);
				if (imm[16])
					prog.push_back(encodeR(functList[$unsigned(imm) % 5], rd, rs, rt));
				else
					prog.push_back(encodeI(addi, rt, rs, imm));
			end
			prog.push_back(encodeHalt());
			loadProgram();
			runAndCheck();
		end
		finishTest(6, "random programs", errorsBefore);

		$display("%0d of 6 tests passed, %0d errors", testsPassed, errorCount);
		if (errorCount == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// the watchdog budget grows with every program that is loaded and run
	initial begin
		while (cycleCount <= cycleBudget) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout: the run did not finish within %0d cycles", cycleBudget);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== processor.f ====
+incdir+verilog
verilog/isaPkg.sv
verilog/corePkg.sv
verilog/ctrlIf.sv
verilog/controlUnit.sv
verilog/registerFile.sv
verilog/alu.sv
verilog/wordMemory.sv
verilog/processor.sv
bench/processorTb.sv

// ==== verilog/alu.sv ====
// alu: 32-bit add, subtract, and, or and signed set-less-than with a zero flag
module alu import corePkg::*; (
	input word_t operand1,
	input word_t operand2,
	input aluOp_e op,
	output word_t result,
	output logic zero
);

	always_comb begin
		case (op)
			aluAdd: result = operand1 + operand2;
			aluSub: result = operand1 - operand2;
			aluAnd: result = operand1 & operand2;
			aluOr: result = operand1 | operand2;
			aluSlt: begin
				result = '0;
				result[0] = $signed(operand1) < $signed(operand2); // two's complement compare
			end
			default: result = '0;
		endcase
	end

	assign zero = (result == '0); // beq tests this after a subtract

endmodule

// ==== verilog/controlUnit.sv ====
// controlUnit: decodes opcode and funct into datapath controls and the halt request
module controlUnit import isaPkg::*, corePkg::*; (
	input instr_t instr,
	ctrlIf.decoder ctrl
);

	always_comb begin
		ctrl.regDst = 1'b0;
		ctrl.aluSrc = 1'b0;
		ctrl.memToReg = 1'b0;
		ctrl.regWrite = 1'b0;
		ctrl.memWrite = 1'b0;
		ctrl.branch = 1'b0;
		ctrl.aluOp = aluAdd;
		ctrl.haltReq = 1'b0;

		case (instr.opcode)
			rType: begin
				ctrl.regDst = 1'b1;
				ctrl.regWrite = 1'b1;
				case (instr.funct)
					add: ctrl.aluOp = aluAdd;
					sub: ctrl.aluOp = aluSub;
					andOp: ctrl.aluOp = aluAnd;
					orOp: ctrl.aluOp = aluOr;
					slt: ctrl.aluOp = aluSlt;
					default: ctrl.regWrite = 1'b0; // unknown funct does nothing
				endcase
			end
			addi: begin
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			lw: begin
				ctrl.aluSrc = 1'b1; // base plus offset
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			sw: begin
				ctrl.aluSrc = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			beq: begin
				ctrl.aluOp = aluSub; // equal operands give a zero result
				ctrl.branch = 1'b1;
			end
			hlt: begin
				ctrl.haltReq = 1'b1;
			end
			default: ; // an unknown opcode keeps every write control low and acts as a no-op
		endcase
	end

endmodule

// ==== verilog/corePkg.sv ====
// corePkg: microarchitecture types for data words, addresses, ALU operations and run state
`include "core_macros.svh"

package corePkg;

	typedef logic [31:0] word_t;

	typedef logic [`PC_WIDTH-1:0] pc_t;

	typedef logic [`REG_ADDR_WIDTH-1:0] regAddr_t;

	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr = 3'd3,
		aluSlt = 3'd4
	} aluOp_e;

	// halted differs from idle only in that a program has run since reset
	typedef enum logic [1:0] {
		idle = 2'd0,
		run = 2'd1,
		halted = 2'd2
	} runState_e;

endpackage

// ==== verilog/core_macros.svh ====
// core macros: widths and depths of the program counter, register file and memories
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// the PC addresses the instruction memory directly, one word per step
`define PC_WIDTH 6
`define IMEM_DEPTH 64

`define DMEM_DEPTH 256

`define REG_COUNT 32
`define REG_ADDR_WIDTH 5

`endif

// ==== verilog/ctrlIf.sv ====
// ctrlIf: decoded control signals passed from the control unit to the datapath
interface ctrlIf import corePkg::*; ();

	logic regDst; // write rd rather than rt
	logic aluSrc; // second ALU operand is the immediate
	logic memToReg;
	logic regWrite;
	logic memWrite;
	logic branch;
	aluOp_e aluOp;
	logic haltReq;

	modport decoder (
		output regDst, aluSrc, memToReg, regWrite, memWrite, branch, aluOp, haltReq
	);

	modport datapath (
		input regDst, aluSrc, memToReg, regWrite, memWrite, branch, aluOp, haltReq
	);

endinterface

// ==== verilog/isaPkg.sv ====
// isaPkg: instruction encoding with opcode and funct values and the instruction field layout
package isaPkg;

	typedef enum logic [5:0] {
		rType = 6'd0,
		beq = 6'd4,
		addi = 6'd8,
		lw = 6'd35,
		sw = 6'd43,
		hlt = 6'd63
	} opcode_e;

	typedef enum logic [5:0] {
		add = 6'd32,
		sub = 6'd34,
		andOp = 6'd36,
		orOp = 6'd37,
		slt = 6'd42
	} funct_e;

	// R-type layout with the I-type fields overlaying it
	typedef struct packed {
		opcode_e opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funct_e funct;
	} instr_t;

	typedef union packed {
		instr_t instr;
		struct packed {
			logic [15:0] upper; // opcode, rs and rt
			logic [15:0] imm;
		} immView;
	} instrImm_t;

endpackage

// ==== verilog/processor.sv ====
// processor: single-cycle core with run sequencer, program load port and debug register read
`include "core_macros.svh"

module processor import isaPkg::*, corePkg::*; (
	input logic clk,
	input logic rst,
	input logic loadValid,
	output logic loadReady,
	input pc_t loadAddr,
	input logic [31:0] loadInstr,
	input logic start,
	output pc_t pc,
	output logic halted,
	output logic [31:0] cyclesConsumed,
	input logic [4:0] dbgAddr,
	output logic [31:0] dbgData
);

	localparam int dAddrWidth = $clog2(`DMEM_DEPTH);

	runState_e state;
	logic running;

	instr_t instr;
	instrImm_t instrView;
	logic [15:0] imm;
	word_t extImm;

	regAddr_t writeReg;
	word_t readData1;
	word_t readData2;
	word_t aluIn2;
	word_t aluResult;
	logic zero;
	word_t memReadData;
	word_t writeBack;

	pc_t pcPlus1;
	pc_t branchTarget;
	pc_t nextPc;

	ctrlIf ctrl ();

	assign running = (state == run);
	assign loadReady = !running; // host may load only while idle or halted
	assign halted = (state == corePkg::halted);

	// sequencer, PC and cycle counter
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= idle;
			pc <= '0;
			cyclesConsumed <= '0;
		end else if (running) begin
			cyclesConsumed <= cyclesConsumed + 32'd1; // the hlt cycle counts too
			if (ctrl.haltReq) begin
				state <= corePkg::halted; // pc stays on the hlt
			end else begin
				pc <= nextPc;
			end
		end else if (start) begin
			state <= run;
			pc <= '0;
			cyclesConsumed <= '0;
		end
	end

	wordMemory #(
		.wordType(instr_t),
		.depth(`IMEM_DEPTH)
	) instrMem (
		.clk(clk),
		.write(loadValid && loadReady),
		.writeAddr(loadAddr),
		.readAddr(pc),
		.writeData(instr_t'(loadInstr)),
		.readData(instr)
	);

	controlUnit u_controlUnit (
		.instr(instr),
		.ctrl(ctrl)
	);

	assign instrView.instr = instr;
	assign imm = instrView.immView.imm;
	assign extImm = {{16{imm[15]}}, imm};

	assign writeReg = ctrl.regDst ? instr.rd : instr.rt;

	registerFile u_registerFile (
		.clk(clk),
		.rst(rst),
		.write(ctrl.regWrite && running),
		.readAddr1(instr.rs),
		.readAddr2(instr.rt),
		.writeAddr(writeReg),
		.dbgAddr(dbgAddr),
		.writeData(writeBack),
		.readData1(readData1),
		.readData2(readData2),
		.dbgData(dbgData)
	);

	assign aluIn2 = ctrl.aluSrc ? extImm : readData2;

	alu u_alu (
		.operand1(readData1),
		.operand2(aluIn2),
		.op(ctrl.aluOp),
		.result(aluResult),
		.zero(zero)
	);

	// word addressed, so the low address bits select the word directly
	wordMemory #(
		.wordType(word_t),
		.depth(`DMEM_DEPTH)
	) dataMem (
		.clk(clk),
		.write(ctrl.memWrite && running),
		.writeAddr(aluResult[dAddrWidth-1:0]),
		.readAddr(aluResult[dAddrWidth-1:0]),
		.writeData(readData2),
		.readData(memReadData)
	);

	assign writeBack = ctrl.memToReg ? memReadData : aluResult;

	assign pcPlus1 = pc + pc_t'(1);
	assign branchTarget = pc + imm[`PC_WIDTH-1:0]; // offset from the branch itself
	assign nextPc = (ctrl.branch && zero) ? branchTarget : pcPlus1;

endmodule

// ==== verilog/registerFile.sv ====
// registerFile: 32 general registers with two operand reads, a debug read and one write
`include "core_macros.svh"

module registerFile import corePkg::*; (
	input logic clk,
	input logic rst,
	input logic write,
	input regAddr_t readAddr1,
	input regAddr_t readAddr2,
	input regAddr_t writeAddr,
	input regAddr_t dbgAddr,
	input word_t writeData,
	output word_t readData1,
	output word_t readData2,
	output word_t dbgData
);

	word_t regs [`REG_COUNT];

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (write && writeAddr != '0) begin
			regs[writeAddr] <= writeData; // register 0 is never written
		end
	end

	// a read in the writing cycle sees the old value since there is no bypass
	always_comb begin
		readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
		readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];
		dbgData = (dbgAddr == '0) ? '0 : regs[dbgAddr];
	end

endmodule

// ==== verilog/wordMemory.sv ====
// wordMemory: word storage with one clocked write port and one combinational read port
module wordMemory import corePkg::*; #(
	parameter type wordType = word_t,
	parameter int depth = 256
) (
	input logic clk,
	input logic write,
	input logic [$clog2(depth)-1:0] writeAddr,
	input logic [$clog2(depth)-1:0] readAddr,
	input wordType writeData,
	output wordType readData
);

	wordType mem [depth];

	// contents are undefined until written
	always_ff @(posedge clk) begin
		if (write) begin
			mem[writeAddr] <= writeData;
		end
	end

	assign readData = mem[readAddr];

endmodule
